//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    ////////////////////
    // geometry

    localparam int num_ways    = 4;
    localparam int num_sets    = 128;
    localparam int index_bits  = 7;
    localparam int tag_bits    = 20;
    localparam int word_bits   = 32;
    localparam int line_words  = 8;
    localparam int half_words  = 4;
    localparam int line_bits   = line_words * word_bits;
    localparam int half_bits   = half_words * word_bits;
    // one bus beat per word
    localparam int burst_beats = line_words;

    typedef logic [index_bits-1:0] set_index_t;
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [num_ways-1:0]   way_onehot_t;
    typedef logic [line_bits-1:0]  line_t;
    typedef logic [half_bits-1:0]  half_line_t;
    typedef logic [2:0]            plru_bits_t;

    ////////////////////
    // request and bus records

    // tag, index and half form the address above the 16-byte offset
    typedef struct packed {
        tag_t       tag;
        set_index_t index;
        logic       half;
    } fetch_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } rd_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        valid;
    } rd_beat_t;

    typedef enum logic [2:0] {
        st_reset   = 3'd0,
        st_idle    = 3'd1,
        st_run     = 3'd2,
        st_miss    = 3'd3,
        st_refill  = 3'd4,
        st_finish  = 3'd5,
        st_recover = 3'd6
    } cache_state_t;

endpackage

`default_nettype wire

//--- icache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 128
) (
    input  wire                    clk,
    input  wire                    wen,
    input  wire icache_pkg::set_index_t index,
    input  wire entry_t            wdata,
    output entry_t                 rdata
);

    entry_t mem [depth];

    // read-first, the old entry comes out during a write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

    // the sweep and the fill must address a real set
    a_index_known: assert property (
        @(posedge clk) wen |-> !$isunknown(index)
    );

endmodule

`default_nettype wire

//--- icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            req,
    input  wire icache_pkg::fetch_req_t    fetch,
    output logic                           index_ok,
    output logic                           data_ok,
    output icache_pkg::half_line_t         rdata,
    input  wire icache_pkg::cache_state_t  state,
    input  wire icache_pkg::tagv_entry_t   tagv [icache_pkg::num_ways],
    input  wire icache_pkg::line_t         lines [icache_pkg::num_ways],
    output icache_pkg::fetch_req_t         st1,
    output logic                           st1_valid,
    output icache_pkg::fetch_req_t         st2,
    output logic                           miss
);
    import icache_pkg::*;

    typedef logic [$clog2(num_ways)-1:0] way_idx_t;

    logic        st2_valid;
    tagv_entry_t tagv_q [num_ways];
    line_t       lines_q [num_ways];
    logic        state_ok;
    logic        advance;
    way_onehot_t hit_way;
    logic        hit;
    way_idx_t    hit_idx;
    line_t       hit_line;

    // stage two is free or its result leaves this cycle
    assign advance  = !st2_valid || data_ok;
    assign state_ok = state inside {st_run, st_recover, st_idle};
    assign index_ok = state_ok && advance;

    ////////////////////
    // stage one

    always_ff @(posedge clk) begin
        if (!rst) begin
            st1_valid <= 1'b0;
        end else if (advance) begin
            st1_valid <= req && index_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (req && index_ok) begin
            st1 <= fetch;
        end
    end

    ////////////////////
    // stage two

    always_ff @(posedge clk) begin
        if (!rst) begin
            st2_valid <= 1'b0;
        end else if (advance) begin
            st2_valid <= st1_valid;
        end
    end

    // idle rereads the arrays after a fill without moving the request
    always_ff @(posedge clk) begin
        if (advance) begin
            st2 <= st1;
        end
        if (advance || state == st_idle) begin
            for (int w = 0; w < num_ways; w++) begin
                tagv_q[w]  <= tagv[w];
                lines_q[w] <= lines[w];
            end
        end
    end

    ////////////////////
    // tag compare

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = tagv_q[w].valid && (tagv_q[w].tag == st2.tag);
        end
    end

    assign hit = |hit_way;

    // at most one way matches
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                hit_idx = way_idx_t'(w);
            end
        end
    end

    assign hit_line = lines_q[hit_idx];
    assign rdata    = st2.half ? hit_line[line_bits-1:half_bits] : hit_line[half_bits-1:0];

    assign data_ok = (state == st_run) && st2_valid && hit;
    assign miss    = (state == st_run) && st2_valid && !hit;

    // a result comes from exactly one matching way
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst)
        data_ok |-> $onehot(hit_way)
    );

endmodule

`default_nettype wire

//--- icache_plru.sv
`timescale 1ns/1ps
`default_nettype none

module icache_plru (
    input  wire                           clk,
    input  wire                           rst,
    input  wire icache_pkg::cache_state_t state,
    input  wire                           miss,
    input  wire icache_pkg::set_index_t   index,
    output icache_pkg::way_onehot_t       victim
);
    import icache_pkg::*;

    plru_bits_t plru_q [num_sets];
    plru_bits_t cur;
    way_onehot_t choice;

    assign cur = plru_q[index];

    // bit 0 picks the pair and bits 1 and 2 pick inside it
    always_comb begin
        if (!cur[0]) begin
            choice = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            choice = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            victim <= '0;
        end else if (state == st_run && miss) begin
            victim <= choice;
        end
    end

    // point the tree away from the chosen way
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < num_sets; s++) begin
                plru_q[s] <= '0;
            end
        end else if (state == st_miss) begin
            case (victim)
                4'b0001: plru_q[index] <= {cur[2], 1'b1, 1'b1};
                4'b0010: plru_q[index] <= {cur[2], 1'b0, 1'b1};
                4'b0100: plru_q[index] <= {1'b1, cur[1], 1'b0};
                4'b1000: plru_q[index] <= {1'b0, cur[1], 1'b0};
                default: plru_q[index] <= cur;
            endcase
        end
    end

    // after the update the tree no longer points at the victim
    a_points_away: assert property (
        @(posedge clk) disable iff (!rst)
        state == st_miss |=> (victim & choice) == '0
    );

endmodule

`default_nettype wire

//--- icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  wire                           clk,
    input  wire                           rst,
    input  wire icache_pkg::cache_state_t state,
    input  wire icache_pkg::fetch_req_t   miss_req,
    output icache_pkg::rd_addr_t          ar,
    input  wire                           arready,
    input  wire icache_pkg::rd_beat_t     r,
    output logic                          rready,
    output logic                          fill_done,
    output icache_pkg::line_t             fill_line,
    output icache_pkg::fetch_req_t        fill_req
);
    import icache_pkg::*;

    typedef logic [$clog2(burst_beats)-1:0] beat_idx_t;

    logic                 ar_pending;
    beat_idx_t            beat_q;
    logic [word_bits-1:0] fill_buf [line_words];
    logic                 beat_take;

    assign rready    = (state == st_refill);
    assign beat_take = r.valid && rready;
    assign fill_done = beat_take && r.last;

    // the half-line start lets the wrapping burst open with the fetched word
    assign ar = '{addr: {fill_req, 4'b0000}, valid: ar_pending};

    ////////////////////
    // address phase

    always_ff @(posedge clk) begin
        if (!rst) begin
            ar_pending <= 1'b0;
        end else if (state == st_miss) begin
            if (!ar_pending) begin
                ar_pending <= 1'b1;
            end else if (arready) begin
                ar_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_miss && !ar_pending) begin
            fill_req <= miss_req;
        end
    end

    ////////////////////
    // data phase

    // counter wraps modulo the burst length
    always_ff @(posedge clk) begin
        if (!rst) begin
            beat_q <= '0;
        end else if (state == st_miss && !ar_pending) begin
            beat_q <= miss_req.half ? beat_idx_t'(half_words) : '0;
        end else if (beat_take) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            fill_buf[beat_q] <= r.data;
        end
    end

    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            fill_line[i*word_bits +: word_bits] = fill_buf[i];
        end
    end

    // the last beat fills the slot just before the first one
    a_last_wraps: assert property (
        @(posedge clk) disable iff (!rst)
        fill_done |-> beat_idx_t'(beat_q + 1'b1) == (fill_req.half ? beat_idx_t'(half_words) : '0)
    );

    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr)
    );

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         miss,
    input  wire                         arready,
    input  wire                         fill_done,
    input  wire icache_pkg::fetch_req_t st1,
    input  wire                         st1_valid,
    input  wire icache_pkg::fetch_req_t st2,
    input  wire icache_pkg::fetch_req_t fetch,
    input  wire icache_pkg::fetch_req_t fill_req,
    input  wire icache_pkg::way_onehot_t victim,
    output icache_pkg::cache_state_t    state,
    output icache_pkg::set_index_t      arr_index,
    output icache_pkg::way_onehot_t     tag_wen,
    output icache_pkg::way_onehot_t     data_wen,
    output icache_pkg::tagv_entry_t     tagv_wdata
);
    import icache_pkg::*;

    set_index_t   sweep_q;
    cache_state_t state_nx;

    ////////////////////
    // state machine

    always_comb begin
        state_nx = state;
        case (state)
            st_reset:   state_nx = (sweep_q == set_index_t'(num_sets - 1)) ? st_idle : st_reset;
            st_idle:    state_nx = st_run;
            st_run:     state_nx = miss ? st_miss : st_run;
            st_miss:    state_nx = arready ? st_refill : st_miss;
            st_refill:  state_nx = fill_done ? st_finish : st_refill;
            st_finish:  state_nx = st_recover;
            // recover reads the set back, idle lands it in stage two
            st_recover: state_nx = st_idle;
            default:    state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_reset;
        end else begin
            state <= state_nx;
        end
    end

    // one set invalidated per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            sweep_q <= '0;
        end else if (state == st_reset) begin
            sweep_q <= sweep_q + 1'b1;
        end
    end

    ////////////////////
    // array steering

    always_comb begin
        case (state)
            st_reset:  arr_index = sweep_q;
            st_finish: arr_index = fill_req.index;
            st_run:    arr_index = fetch.index;
            // after reset stage one may be empty and a new request arrives
            st_idle:   arr_index = st1_valid ? st1.index : fetch.index;
            default:   arr_index = st2.index;
        endcase
    end

    always_comb begin
        tag_wen  = '0;
        data_wen = '0;
        if (state == st_reset) begin
            tag_wen = '1;
        end else if (state == st_finish) begin
            tag_wen  = victim;
            data_wen = victim;
        end
    end

    assign tagv_wdata = (state == st_reset) ? '{tag: '0, valid: 1'b0}
                                            : '{tag: fill_req.tag, valid: 1'b1};

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req,
    input  wire icache_pkg::fetch_req_t fetch,
    output logic                        index_ok,
    output logic                        data_ok,
    output icache_pkg::half_line_t      rdata,
    output icache_pkg::rd_addr_t        ar,
    input  wire                         arready,
    input  wire icache_pkg::rd_beat_t   r,
    output logic                        rready
);
    import icache_pkg::*;

    cache_state_t state;
    fetch_req_t   st1;
    fetch_req_t   st2;
    fetch_req_t   fill_req;
    logic         st1_valid;
    logic         miss;
    logic         fill_done;
    logic         ar_accept;
    line_t        fill_line;
    way_onehot_t  victim;
    way_onehot_t  tag_wen;
    way_onehot_t  data_wen;
    set_index_t   arr_index;
    tagv_entry_t  tagv_wdata;
    tagv_entry_t  tagv_rd [num_ways];
    line_t        line_rd [num_ways];

    // address handshake completes only once valid is up
    assign ar_accept = ar.valid && arready;

    icache_lookup u_lookup (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .fetch     (fetch),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .state     (state),
        .tagv      (tagv_rd),
        .lines     (line_rd),
        .st1       (st1),
        .st1_valid (st1_valid),
        .st2       (st2),
        .miss      (miss)
    );

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .miss       (miss),
        .arready    (ar_accept),
        .fill_done  (fill_done),
        .st1        (st1),
        .st1_valid  (st1_valid),
        .st2        (st2),
        .fetch      (fetch),
        .fill_req   (fill_req),
        .victim     (victim),
        .state      (state),
        .arr_index  (arr_index),
        .tag_wen    (tag_wen),
        .data_wen   (data_wen),
        .tagv_wdata (tagv_wdata)
    );

    icache_plru u_plru (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .miss   (miss),
        .index  (st2.index),
        .victim (victim)
    );

    icache_refill u_refill (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .miss_req  (st2),
        .ar        (ar),
        .arready   (arready),
        .r         (r),
        .rready    (rready),
        .fill_done (fill_done),
        .fill_line (fill_line),
        .fill_req  (fill_req)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        icache_sram #(.entry_t(tagv_entry_t), .depth(num_sets)) u_tagv (
            .clk   (clk),
            .wen   (tag_wen[w]),
            .index (arr_index),
            .wdata (tagv_wdata),
            .rdata (tagv_rd[w])
        );

        icache_sram #(.entry_t(line_t), .depth(num_sets)) u_data (
            .clk   (clk),
            .wen   (data_wen[w]),
            .index (arr_index),
            .wdata (fill_line),
            .rdata (line_rd[w])
        );
    end

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire                       clk,
    input  wire                       rst,
    input  wire icache_pkg::rd_addr_t ar,
    output logic                      arready,
    output icache_pkg::rd_beat_t      r,
    input  wire                       rready
);
    import icache_pkg::*;

    logic [31:0] rng;
    logic        busy;
    logic [31:0] base;
    logic [2:0]  beat;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word address of beat n, wrapping inside the 32-byte line
    function automatic logic [31:0] beat_data(input logic [31:0] start, input logic [2:0] n);
        logic [2:0]  slot;
        logic [29:0] waddr;
        slot  = start[4:2] + n;
        waddr = {start[31:5], slot};
        return {2'b00, waddr} ^ 32'h5a5a0000;
    endfunction

    initial begin
        rng     = 32'h632233a2;
        arready = 1'b0;
        r       = '0;
    end

    ////////////////////
    // handshakes, seen on the rising edge

    always @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            beat <= '0;
        end else begin
            if (ar.valid && arready) begin
                busy <= 1'b1;
                base <= ar.addr;
                beat <= '0;
            end
            if (r.valid && rready) begin
                beat <= beat + 1'b1;
                if (r.last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge clk) begin
        rng = xorshift32(rng);
        if (!rst) begin
            arready = 1'b0;
            r       = '0;
        end else begin
            // random address delay, about one beat in four skipped
            arready = ar.valid && !busy && rng[0];
            r.valid = busy && (rng[5:4] != 2'b00);
            r.last  = busy && (beat == 3'(burst_beats - 1));
            r.data  = busy ? beat_data(base, beat) : '0;
        end
    end

endmodule

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    // one fetch, its expected miss, and whether to wait for all results first
    typedef struct packed {
        tag_t       tag;
        set_index_t index;
        logic       half;
        logic       burst;
        logic       drain;
    } test_t;

    localparam int         num_tests = 20;
    localparam tag_t       tag_a     = 20'h01234;
    localparam tag_t       tag_b     = 20'h0abcd;
    localparam tag_t       tag_c     = 20'h10000;
    localparam tag_t       tag_d     = 20'hfffff;
    localparam tag_t       tag_e     = 20'h55555;
    localparam set_index_t set_x     = 7'h15;
    localparam set_index_t set_y     = 7'h7f;

    // plru bits {2,1,0} of set_x noted after each miss
    test_t tests [num_tests] = '{
        {tag_a, set_x, 1'b0, 1'b1, 1'b1},  // way 0, 011
        {tag_a, set_x, 1'b0, 1'b0, 1'b1},
        {tag_a, set_x, 1'b1, 1'b0, 1'b0},
        {tag_b, set_x, 1'b1, 1'b1, 1'b0},  // way 2, 110
        {tag_c, set_x, 1'b0, 1'b1, 1'b0},  // way 1, 101
        {tag_d, set_x, 1'b1, 1'b1, 1'b0},  // way 3, 000
        {tag_e, set_x, 1'b0, 1'b1, 1'b0},  // way 0 drops a, 011
        {tag_a, set_x, 1'b0, 1'b1, 1'b0},  // way 2 drops b, 110
        {tag_b, set_x, 1'b1, 1'b1, 1'b0},  // way 1 drops c, 101
        {tag_d, set_x, 1'b0, 1'b0, 1'b0},
        {tag_e, set_x, 1'b1, 1'b0, 1'b0},
        {tag_c, set_x, 1'b0, 1'b1, 1'b0},  // way 3 drops d, 000
        {tag_a, set_x, 1'b1, 1'b0, 1'b1},
        {tag_d, set_x, 1'b1, 1'b1, 1'b0},  // way 0 drops e, 011
        {tag_b, set_x, 1'b0, 1'b0, 1'b1},
        {tag_a, set_x, 1'b1, 1'b0, 1'b0},
        {tag_c, set_x, 1'b0, 1'b0, 1'b0},
        {tag_d, set_x, 1'b1, 1'b0, 1'b0},
        {tag_a, set_y, 1'b1, 1'b1, 1'b0},
        {tag_a, set_y, 1'b0, 1'b0, 1'b0}
    };

    logic       clk;
    logic       rst;
    logic       req;
    fetch_req_t fetch;
    logic       index_ok;
    logic       data_ok;
    half_line_t rdata;
    rd_addr_t   ar;
    logic       arready;
    rd_beat_t   r;
    logic       rready;

    int       cycle        = 0;
    int       live_edges   = 0;
    int       accept_count = 0;
    int       done_count   = 0;
    int       burst_count  = 0;
    int       accept_cycle [num_tests];
    rd_addr_t last_ar;
    logic     burst_open   = 1'b0;

    icache_top dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .fetch    (fetch),
        .index_ok (index_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .ar       (ar),
        .arready  (arready),
        .r        (r),
        .rready   (rready)
    );

    tb_axi_mem mem (
        .clk     (clk),
        .rst     (rst),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////
    // checks

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_rdata(input string name, input half_line_t got, input half_line_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic verify_burst_addr(input string name, input rd_addr_t got, input rd_addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s got %h expected %h", name, got.addr, exp.addr));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // each word of the half is its word address xor a fixed pattern
    function automatic half_line_t expected_half(input test_t t);
        half_line_t  h;
        logic [29:0] waddr;
        for (int j = 0; j < half_words; j++) begin
            waddr = {t.tag, t.index, t.half, 2'(j)};
            h[j*word_bits +: word_bits] = {2'b00, waddr} ^ 32'h5a5a0000;
        end
        return h;
    endfunction

    task automatic score_result(input int i);
        test_t    t;
        rd_addr_t exp_ar;
        logic     prior_hit;
        t         = tests[i];
        exp_ar    = '{addr: {t.tag, t.index, t.half, 4'h0}, valid: 1'b1};
        prior_hit = (i == 0) ? 1'b1 : !tests[i-1].burst;
        check_flag($sformatf("burst_seen[%0d]", i), burst_count != 0, t.burst);
        if (burst_count > 1) begin
            stop_with_error($sformatf("request %0d caused %0d bursts", i, burst_count));
        end
        if (t.burst) begin
            verify_burst_addr($sformatf("ar.addr[%0d]", i), last_ar, exp_ar);
        end
        compare_rdata($sformatf("rdata[%0d]", i), rdata, expected_half(t));
        // a hit behind a hit returns two edges after acceptance
        if (!t.burst && (t.drain || prior_hit) && cycle - accept_cycle[i] != 2) begin
            stop_with_error($sformatf("request %0d hit returned %0d edges after acceptance",
                                      i, cycle - accept_cycle[i]));
        end
    endtask

    // sampled on the rising edge before the DUT registers update
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst) begin
            live_edges = live_edges + 1;
            if (live_edges <= num_sets && (index_ok || data_ok || ar.valid || rready)) begin
                stop_with_error($sformatf("handshake output high %0d edges after reset release",
                                          live_edges));
            end
            // data is taken only between the address handshake and the last beat
            check_flag("rready", rready, burst_open);
            if (req && index_ok) begin
                if (accept_count >= num_tests) begin
                    stop_with_error("request accepted with no table entry behind it");
                end
                accept_cycle[accept_count] = cycle;
                accept_count = accept_count + 1;
            end
            if (ar.valid && arready) begin
                burst_count = burst_count + 1;
                last_ar     = ar;
                burst_open  = 1'b1;
            end
            if (r.valid && rready && r.last) begin
                burst_open = 1'b0;
            end
            if (data_ok) begin
                if (done_count >= accept_count) begin
                    stop_with_error("data_ok pulsed with no request outstanding");
                end
                score_result(done_count);
                done_count  = done_count + 1;
                burst_count = 0;
            end
        end
    end

    ////////////////////
    // stimulus

    initial begin
        rst   = 1'b0;
        req   = 1'b0;
        fetch = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            if (tests[i].drain) begin
                req = 1'b0;
                while (done_count < i) @(negedge clk);
            end
            req   = 1'b1;
            fetch = '{tag: tests[i].tag, index: tests[i].index, half: tests[i].half};
            while (accept_count <= i) @(negedge clk);
        end
        req = 1'b0;
        while (done_count < num_tests) @(negedge clk);
        // no stray result after the last one
        repeat (4) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

    // covers the reset sweep plus the worst refill per entry
    initial begin
        repeat (num_tests * 200 + 400) @(posedge clk);
        stop_with_error($sformatf("timeout with %0d of %0d results returned",
                                  done_count, num_tests));
    end

endmodule

`default_nettype wire

//--- filelist.f
icache_pkg.sv
icache_sram.sv
icache_lookup.sv
icache_plru.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_axi_mem.sv
tb_icache.sv
